// ==== common/core_pkg.sv ====
//####################
// core package
// widths, rv32i encodings and the control enums
// shared by the pipeline stages
//####################
package core_pkg;

	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;

	localparam logic [XLEN-1:0] INSTR_NOP = 32'h0000_0013;	// addi x0,x0,0

	typedef enum logic [6:0] {
		OP     = 7'b0110011,
		OP_IMM = 7'b0010011,
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011,
		BRANCH = 7'b1100011,
		JAL    = 7'b1101111
	} opcode_e;

	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;
	localparam logic [2:0] F3_WORD    = 3'b010;	// lw / sw
	localparam logic [2:0] F3_BEQ     = 3'b000;
	localparam logic [2:0] F3_BNE     = 3'b001;

	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_SUB  = 7'b0100000;

	typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR} alu_op_e;

	typedef enum logic [1:0] {JMP_NONE, JMP_BEQ, JMP_BNE, JMP_JAL} jmp_flag_e;

	// fetch hold bubbles ID/EX, full hold freezes every stage
	typedef enum logic [1:0] {HOLD_NONE, HOLD_FETCH, HOLD_ALL} hold_code_e;

endpackage

// ==== src/pc.sv ====
//####################
// pc
// fetch address register, advances by one word
// unless held or redirected by a taken jump
//####################
`timescale 1ns/1ps

module pc #(
	parameter logic [core_pkg::XLEN-1:0] RESET_PC = '0
) (
	input  logic                       clk_i,
	input  logic                       rst_i,
	input  core_pkg::hold_code_e       hold_code_i,
	input  logic                       jmp_en_i,
	input  logic [core_pkg::XLEN-1:0]  jmp_to_i,
	output logic [core_pkg::XLEN-1:0]  pc_o
);

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			pc_o <= RESET_PC;
		end else if (jmp_en_i && hold_code_i != core_pkg::HOLD_ALL) begin
			pc_o <= jmp_to_i;	// redirect
		end else if (hold_code_i == core_pkg::HOLD_NONE) begin
			pc_o <= pc_o + core_pkg::XLEN'(4);
		end
	end

	// targets come from id_stage immediates, so the whole loop must keep alignment
	a_pc_aligned : assert property (@(posedge clk_i) disable iff (rst_i)
		pc_o[1:0] == 2'b00);

endmodule

// ==== src/if_stage.sv ====
//####################
// if_stage
// IF/ID register, turns a flushed fetch into a nop
//####################
`timescale 1ns/1ps

module if_stage (
	input  logic                       clk_i,
	input  logic                       rst_i,
	input  core_pkg::hold_code_e       hold_code_i,
	input  logic [core_pkg::XLEN-1:0]  instr_i,
	input  logic [core_pkg::XLEN-1:0]  pc_i,
	input  logic                       instr_mask_i,
	output logic [core_pkg::XLEN-1:0]  instr_o,
	output logic [core_pkg::XLEN-1:0]  pc_o,
	output logic                       instr_rd_en_o
);

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			instr_o <= core_pkg::INSTR_NOP;
		end else if (hold_code_i == core_pkg::HOLD_NONE) begin
			if (instr_mask_i) begin
				instr_o <= core_pkg::INSTR_NOP;	// wrong-path fetch
			end else begin
				instr_o <= instr_i;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (hold_code_i == core_pkg::HOLD_NONE) begin
			pc_o <= pc_i;
		end
	end

	assign instr_rd_en_o = (hold_code_i != core_pkg::HOLD_ALL);

endmodule

// ==== id_stage/id_stage.sv ====
//####################
// id_stage
// decoder, operand bypass, branch operands and target
// and the ID/EX pipeline register
//####################
`timescale 1ns/1ps

module id_stage (
	input  logic                             clk_i,
	input  logic                             rst_i,
	input  core_pkg::hold_code_e             hold_code_i,
	input  logic [core_pkg::XLEN-1:0]        instr_i,
	input  logic [core_pkg::XLEN-1:0]        pc_i,
	input  logic [core_pkg::XLEN-1:0]        data_rs1_i,
	input  logic [core_pkg::XLEN-1:0]        data_rs2_i,
	input  logic [core_pkg::XLEN-1:0]        bypass_data_i,
	input  logic [core_pkg::REG_ADDR_W-1:0]  bypass_addr_i,
	input  logic                             bypass_en_i,
	output logic [core_pkg::REG_ADDR_W-1:0]  addr_rs1_o,
	output logic [core_pkg::REG_ADDR_W-1:0]  addr_rs2_o,
	output logic [core_pkg::XLEN-1:0]        jmpb_rs1_o,
	output logic [core_pkg::XLEN-1:0]        jmpb_rs2_o,
	output logic [core_pkg::XLEN-1:0]        jmp_to_o,
	output core_pkg::jmp_flag_e              jmp_flag_o,
	output logic [core_pkg::REG_ADDR_W-1:0]  ex_load_rd_o,
	output logic                             ex_load_o,
	output core_pkg::alu_op_e                alu_op_o,
	output logic [core_pkg::XLEN-1:0]        op_num1_o,
	output logic [core_pkg::XLEN-1:0]        op_num2_o,
	output logic [core_pkg::XLEN-1:0]        store_data_o,
	output logic                             load_o,
	output logic                             store_o,
	output logic [core_pkg::REG_ADDR_W-1:0]  addr_wr_o,
	output logic                             reg_wr_en_o
);

	core_pkg::opcode_e                opcode;
	logic [2:0]                       funct3;
	logic [6:0]                       funct7;
	logic [core_pkg::REG_ADDR_W-1:0]  rd;
	logic [core_pkg::XLEN-1:0]        imm_i;
	logic [core_pkg::XLEN-1:0]        imm_s;
	logic [core_pkg::XLEN-1:0]        imm_b;
	logic [core_pkg::XLEN-1:0]        imm_j;
	logic                             fwd_ok;
	logic [core_pkg::XLEN-1:0]        rs1_val;
	logic [core_pkg::XLEN-1:0]        rs2_val;
	core_pkg::alu_op_e                dec_op;
	core_pkg::jmp_flag_e              dec_jmp;
	logic [core_pkg::XLEN-1:0]        dec_num1;
	logic [core_pkg::XLEN-1:0]        dec_num2;
	logic                             dec_load;
	logic                             dec_store;
	logic                             dec_wr;

	assign opcode     = core_pkg::opcode_e'(instr_i[6:0]);
	assign funct3     = instr_i[14:12];
	assign funct7     = instr_i[31:25];
	assign rd         = instr_i[11:7];
	assign addr_rs1_o = instr_i[19:15];
	assign addr_rs2_o = instr_i[24:20];

	assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
	assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
	assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
	assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

	// a load in EX has no data yet, ctrl holds instead
	assign fwd_ok  = bypass_en_i && !load_o;
	assign rs1_val = (fwd_ok && bypass_addr_i == addr_rs1_o) ? bypass_data_i : data_rs1_i;
	assign rs2_val = (fwd_ok && bypass_addr_i == addr_rs2_o) ? bypass_data_i : data_rs2_i;

	always_comb begin
		dec_op    = core_pkg::ALU_ADD;
		dec_jmp   = core_pkg::JMP_NONE;
		dec_num1  = rs1_val;
		dec_num2  = imm_i;
		dec_load  = 1'b0;
		dec_store = 1'b0;
		dec_wr    = 1'b0;
		case (opcode)
			core_pkg::OP: begin
				dec_num2 = rs2_val;
				dec_wr   = (funct7 == core_pkg::F7_BASE);
				case (funct3)
					core_pkg::F3_ADD_SUB: begin
						dec_wr = (funct7 == core_pkg::F7_BASE) || (funct7 == core_pkg::F7_SUB);
						if (funct7 == core_pkg::F7_SUB) begin
							dec_op = core_pkg::ALU_SUB;
						end
					end
					core_pkg::F3_XOR: dec_op = core_pkg::ALU_XOR;
					core_pkg::F3_OR:  dec_op = core_pkg::ALU_OR;
					core_pkg::F3_AND: dec_op = core_pkg::ALU_AND;
					default:          dec_wr = 1'b0;	// shifts, compares
				endcase
			end
			core_pkg::OP_IMM: dec_wr = (funct3 == core_pkg::F3_ADD_SUB);	// addi only
			core_pkg::LOAD: begin
				dec_load = (funct3 == core_pkg::F3_WORD);
				dec_wr   = dec_load;
			end
			core_pkg::STORE: begin
				dec_num2  = imm_s;
				dec_store = (funct3 == core_pkg::F3_WORD);
			end
			core_pkg::BRANCH: begin
				if (funct3 == core_pkg::F3_BEQ) begin
					dec_jmp = core_pkg::JMP_BEQ;
				end else if (funct3 == core_pkg::F3_BNE) begin
					dec_jmp = core_pkg::JMP_BNE;
				end
			end
			core_pkg::JAL: begin
				dec_jmp  = core_pkg::JMP_JAL;
				dec_num1 = pc_i + core_pkg::XLEN'(4);	// link value
				dec_num2 = '0;
				dec_wr   = 1'b1;
			end
			default: ;
		endcase
	end

	assign jmpb_rs1_o = rs1_val;
	assign jmpb_rs2_o = rs2_val;
	assign jmp_flag_o = dec_jmp;
	assign jmp_to_o   = pc_i + ((dec_jmp == core_pkg::JMP_JAL) ? imm_j : imm_b);

	always_ff @(posedge clk_i) begin
		if (rst_i || hold_code_i == core_pkg::HOLD_FETCH) begin
			load_o      <= 1'b0;	// bubble
			store_o     <= 1'b0;
			reg_wr_en_o <= 1'b0;
		end else if (hold_code_i == core_pkg::HOLD_NONE) begin
			load_o      <= dec_load;
			store_o     <= dec_store;
			reg_wr_en_o <= dec_wr && (rd != '0);	// x0 never forwards
		end
	end

	always_ff @(posedge clk_i) begin
		if (hold_code_i == core_pkg::HOLD_NONE) begin
			alu_op_o     <= dec_op;
			op_num1_o    <= dec_num1;
			op_num2_o    <= dec_num2;
			store_data_o <= rs2_val;
			addr_wr_o    <= rd;
		end
	end

	assign ex_load_o    = load_o;
	assign ex_load_rd_o = load_o ? addr_wr_o : '0;

endmodule

// ==== src/regs.sv ====
//####################
// regs
// 32 x 32 register file, two async reads
// x0 reads zero and drops writes
//####################
`timescale 1ns/1ps

module regs (
	input  logic                             clk_i,
	input  logic                             rst_i,
	input  logic                             wr_en_i,
	input  logic [core_pkg::REG_ADDR_W-1:0]  addr_wr_i,
	input  logic [core_pkg::XLEN-1:0]        data_wr_i,
	input  logic [core_pkg::REG_ADDR_W-1:0]  addr_rd1_i,
	input  logic [core_pkg::REG_ADDR_W-1:0]  addr_rd2_i,
	output logic [core_pkg::XLEN-1:0]        data_rd1_o,
	output logic [core_pkg::XLEN-1:0]        data_rd2_o
);

	logic [core_pkg::XLEN-1:0] rf [32];

	always_ff @(posedge clk_i) begin
		if (!rst_i && wr_en_i && addr_wr_i != '0) begin
			rf[addr_wr_i] <= data_wr_i;
		end
	end

	assign data_rd1_o = (addr_rd1_i == '0) ? '0 : rf[addr_rd1_i];
	assign data_rd2_o = (addr_rd2_i == '0) ? '0 : rf[addr_rd2_i];

endmodule

// ==== ex_stage/ex_stage.sv ====
//####################
// ex_stage
// alu, data memory access and writeback select
//####################
`timescale 1ns/1ps

module ex_stage (
	input  core_pkg::hold_code_e             hold_code_i,
	input  logic                             stall_i,
	input  core_pkg::alu_op_e                alu_op_i,
	input  logic [core_pkg::XLEN-1:0]        op_num1_i,
	input  logic [core_pkg::XLEN-1:0]        op_num2_i,
	input  logic [core_pkg::XLEN-1:0]        store_data_i,
	input  logic                             load_i,
	input  logic                             store_i,
	input  logic [core_pkg::REG_ADDR_W-1:0]  addr_wr_i,
	input  logic                             reg_wr_en_i,
	input  logic [core_pkg::XLEN-1:0]        data_mem_i,
	output logic [core_pkg::XLEN-1:0]        alu_result_o,
	output logic [core_pkg::XLEN-1:0]        addr_mem_rd_o,
	output logic [core_pkg::XLEN-1:0]        addr_mem_wr_o,
	output logic [core_pkg::XLEN-1:0]        data_mem_wr_o,
	output logic                             mem_rd_en_o,
	output logic                             mem_wr_en_o,
	output logic [core_pkg::REG_ADDR_W-1:0]  addr_reg_wr_o,
	output logic [core_pkg::XLEN-1:0]        data_reg_wr_o,
	output logic                             reg_wr_en_o
);

	always_comb begin
		case (alu_op_i)
			core_pkg::ALU_SUB: alu_result_o = op_num1_i - op_num2_i;
			core_pkg::ALU_AND: alu_result_o = op_num1_i & op_num2_i;
			core_pkg::ALU_OR:  alu_result_o = op_num1_i | op_num2_i;
			core_pkg::ALU_XOR: alu_result_o = op_num1_i ^ op_num2_i;
			default:           alu_result_o = op_num1_i + op_num2_i;
		endcase
	end

	// lw/sw address is rs1 + imm from the same adder
	assign addr_mem_rd_o = alu_result_o;
	assign addr_mem_wr_o = alu_result_o;
	assign data_mem_wr_o = store_data_i;
	assign mem_rd_en_o   = load_i;
	assign mem_wr_en_o   = store_i;

	assign addr_reg_wr_o = addr_wr_i;
	assign data_reg_wr_o = load_i ? data_mem_i : alu_result_o;
	assign reg_wr_en_o   = reg_wr_en_i && (hold_code_i != core_pkg::HOLD_ALL);	// frozen on stall

	always_comb begin
		a_mem_excl : assert final (!(mem_rd_en_o && mem_wr_en_o));
		// the full freeze must track the external stall exactly
		a_stall_hold : assert final (stall_i == (hold_code_i == core_pkg::HOLD_ALL));
	end

endmodule

// ==== src/ctrl.sv ====
//####################
// ctrl
// branch resolution, load-use and stall holds
//####################
`timescale 1ns/1ps

module ctrl (
	input  logic                             stall_i,
	input  core_pkg::jmp_flag_e              jmp_flag_i,
	input  logic [core_pkg::XLEN-1:0]        jmpb_rs1_i,
	input  logic [core_pkg::XLEN-1:0]        jmpb_rs2_i,
	input  logic [core_pkg::XLEN-1:0]        jmp_to_i,
	input  logic                             ex_load_i,
	input  logic [core_pkg::REG_ADDR_W-1:0]  ex_load_rd_i,
	input  logic [core_pkg::REG_ADDR_W-1:0]  addr_rs1_i,
	input  logic [core_pkg::REG_ADDR_W-1:0]  addr_rs2_i,
	output logic                             jmp_en_o,
	output logic [core_pkg::XLEN-1:0]        jmp_to_o,
	output logic                             instr_mask_o,
	output core_pkg::hold_code_e             hold_code_o
);

	logic load_use;
	logic taken;

	assign load_use = ex_load_i && (ex_load_rd_i != '0) &&
		(ex_load_rd_i == addr_rs1_i || ex_load_rd_i == addr_rs2_i);

	always_comb begin
		case (jmp_flag_i)
			core_pkg::JMP_BEQ: taken = (jmpb_rs1_i == jmpb_rs2_i);
			core_pkg::JMP_BNE: taken = (jmpb_rs1_i != jmpb_rs2_i);
			core_pkg::JMP_JAL: taken = 1'b1;
			default:           taken = 1'b0;
		endcase
	end

	assign jmp_en_o     = taken && !load_use;	// operands stale until the bubble
	assign jmp_to_o     = jmp_to_i;
	assign instr_mask_o = jmp_en_o;

	always_comb begin
		if (stall_i) begin
			hold_code_o = core_pkg::HOLD_ALL;
		end else if (load_use) begin
			hold_code_o = core_pkg::HOLD_FETCH;
		end else begin
			hold_code_o = core_pkg::HOLD_NONE;
		end
	end

endmodule

// ==== src/core.sv ====
//####################
// core
// three stage rv32i subset pipeline top
//####################
`timescale 1ns/1ps

module core #(
	parameter logic [core_pkg::XLEN-1:0] RESET_PC = '0
) (
	input  logic                       clk_i,
	input  logic                       rst_i,
	input  logic                       stall_i,
	output logic [core_pkg::XLEN-1:0]  pc_o,
	input  logic [core_pkg::XLEN-1:0]  instr_i,
	output logic                       instr_rd_en_o,
	output logic [core_pkg::XLEN-1:0]  addr_mem_rd_o,
	output logic                       mem_rd_en_o,
	input  logic [core_pkg::XLEN-1:0]  data_mem_i,
	output logic [core_pkg::XLEN-1:0]  addr_mem_wr_o,
	output logic [core_pkg::XLEN-1:0]  data_mem_wr_o,
	output logic                       mem_wr_en_o
);

	core_pkg::hold_code_e             hold_code;
	logic                             jmp_en;
	logic [core_pkg::XLEN-1:0]        jmp_to;
	logic [core_pkg::XLEN-1:0]        id_jmp_to;
	logic                             instr_mask;
	logic [core_pkg::XLEN-1:0]        if_instr;
	logic [core_pkg::XLEN-1:0]        if_pc;
	logic [core_pkg::REG_ADDR_W-1:0]  addr_rs1;
	logic [core_pkg::REG_ADDR_W-1:0]  addr_rs2;
	logic [core_pkg::XLEN-1:0]        data_rs1;
	logic [core_pkg::XLEN-1:0]        data_rs2;
	logic [core_pkg::XLEN-1:0]        jmpb_rs1;
	logic [core_pkg::XLEN-1:0]        jmpb_rs2;
	core_pkg::jmp_flag_e              jmp_flag;
	logic [core_pkg::REG_ADDR_W-1:0]  ex_load_rd;
	logic                             ex_load;
	core_pkg::alu_op_e                alu_op;
	logic [core_pkg::XLEN-1:0]        op_num1;
	logic [core_pkg::XLEN-1:0]        op_num2;
	logic [core_pkg::XLEN-1:0]        store_data;
	logic                             load;
	logic                             store;
	logic [core_pkg::REG_ADDR_W-1:0]  addr_wr;
	logic                             reg_wr_en;
	logic [core_pkg::XLEN-1:0]        alu_result;
	logic [core_pkg::REG_ADDR_W-1:0]  wb_addr;
	logic [core_pkg::XLEN-1:0]        wb_data;
	logic                             wb_en;

	pc #(.RESET_PC(RESET_PC)) u_pc (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.hold_code_i (hold_code),
		.jmp_en_i    (jmp_en),
		.jmp_to_i    (jmp_to),
		.pc_o        (pc_o)
	);

	if_stage u_if (
		.clk_i         (clk_i),
		.rst_i         (rst_i),
		.hold_code_i   (hold_code),
		.instr_i       (instr_i),
		.pc_i          (pc_o),
		.instr_mask_i  (instr_mask),
		.instr_o       (if_instr),
		.pc_o          (if_pc),
		.instr_rd_en_o (instr_rd_en_o)
	);

	id_stage u_id (
		.clk_i         (clk_i),
		.rst_i         (rst_i),
		.hold_code_i   (hold_code),
		.instr_i       (if_instr),
		.pc_i          (if_pc),
		.data_rs1_i    (data_rs1),
		.data_rs2_i    (data_rs2),
		.bypass_data_i (alu_result),
		.bypass_addr_i (wb_addr),
		.bypass_en_i   (wb_en),
		.addr_rs1_o    (addr_rs1),
		.addr_rs2_o    (addr_rs2),
		.jmpb_rs1_o    (jmpb_rs1),
		.jmpb_rs2_o    (jmpb_rs2),
		.jmp_to_o      (id_jmp_to),
		.jmp_flag_o    (jmp_flag),
		.ex_load_rd_o  (ex_load_rd),
		.ex_load_o     (ex_load),
		.alu_op_o      (alu_op),
		.op_num1_o     (op_num1),
		.op_num2_o     (op_num2),
		.store_data_o  (store_data),
		.load_o        (load),
		.store_o       (store),
		.addr_wr_o     (addr_wr),
		.reg_wr_en_o   (reg_wr_en)
	);

	regs u_regs (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.wr_en_i    (wb_en),
		.addr_wr_i  (wb_addr),
		.data_wr_i  (wb_data),
		.addr_rd1_i (addr_rs1),
		.addr_rd2_i (addr_rs2),
		.data_rd1_o (data_rs1),
		.data_rd2_o (data_rs2)
	);

	ex_stage u_ex (
		.hold_code_i   (hold_code),
		.stall_i       (stall_i),
		.alu_op_i      (alu_op),
		.op_num1_i     (op_num1),
		.op_num2_i     (op_num2),
		.store_data_i  (store_data),
		.load_i        (load),
		.store_i       (store),
		.addr_wr_i     (addr_wr),
		.reg_wr_en_i   (reg_wr_en),
		.data_mem_i    (data_mem_i),
		.alu_result_o  (alu_result),
		.addr_mem_rd_o (addr_mem_rd_o),
		.addr_mem_wr_o (addr_mem_wr_o),
		.data_mem_wr_o (data_mem_wr_o),
		.mem_rd_en_o   (mem_rd_en_o),
		.mem_wr_en_o   (mem_wr_en_o),
		.addr_reg_wr_o (wb_addr),
		.data_reg_wr_o (wb_data),
		.reg_wr_en_o   (wb_en)
	);

	ctrl u_ctrl (
		.stall_i      (stall_i),
		.jmp_flag_i   (jmp_flag),
		.jmpb_rs1_i   (jmpb_rs1),
		.jmpb_rs2_i   (jmpb_rs2),
		.jmp_to_i     (id_jmp_to),
		.ex_load_i    (ex_load),
		.ex_load_rd_i (ex_load_rd),
		.addr_rs1_i   (addr_rs1),
		.addr_rs2_i   (addr_rs2),
		.jmp_en_o     (jmp_en),
		.jmp_to_o     (jmp_to),
		.instr_mask_o (instr_mask),
		.hold_code_o  (hold_code)
	);

endmodule

// ==== tb/tb_core.sv ====
//####################
// tb_core
// directed tests for the pipelined core
// with rom, ram and store log models
//####################
`timescale 1ns/1ps

module tb_core;

	localparam logic [31:0] RESET_PC  = 32'h0;
	localparam int          RUN_LIMIT = 300;

	logic        clk_i;
	logic        rst_i;
	logic        stall_i;
	logic [31:0] pc_o;
	logic [31:0] instr_i;
	logic        instr_rd_en_o;
	logic [31:0] addr_mem_rd_o;
	logic        mem_rd_en_o;
	logic [31:0] data_mem_i;
	logic [31:0] addr_mem_wr_o;
	logic [31:0] data_mem_wr_o;
	logic        mem_wr_en_o;

	logic [31:0] rom [64];
	logic [31:0] ram [64];
	logic [31:0] prog [$];
	logic [31:0] log_addr [$];
	logic [31:0] log_data [$];
	logic [31:0] log_rd_addr [$];
	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];
	logic [31:0] saved_data [$];
	logic [31:0] lcg_state;
	int          errors;
	int          timeouts;

	core #(.RESET_PC(RESET_PC)) u_core (
		.clk_i         (clk_i),
		.rst_i         (rst_i),
		.stall_i       (stall_i),
		.pc_o          (pc_o),
		.instr_i       (instr_i),
		.instr_rd_en_o (instr_rd_en_o),
		.addr_mem_rd_o (addr_mem_rd_o),
		.mem_rd_en_o   (mem_rd_en_o),
		.data_mem_i    (data_mem_i),
		.addr_mem_wr_o (addr_mem_wr_o),
		.data_mem_wr_o (data_mem_wr_o),
		.mem_wr_en_o   (mem_wr_en_o)
	);

	assign instr_i    = rom[pc_o[7:2]];	// async rom
	assign data_mem_i = ram[addr_mem_rd_o[7:2]];

	initial begin
		clk_i = 1'b0;
		forever #4 clk_i = ~clk_i;
	end

	always @(posedge clk_i) begin
		if (!rst_i) begin
			check(instr_rd_en_o == !stall_i, "instr_rd_en_o does not follow stall_i");
		end
		if (!rst_i && mem_rd_en_o === 1'b1 && !stall_i) begin
			log_rd_addr.push_back(addr_mem_rd_o);
		end
		if (!rst_i && mem_wr_en_o === 1'b1 && !stall_i) begin
			log_addr.push_back(addr_mem_wr_o);
			log_data.push_back(data_mem_wr_o);
			ram[addr_mem_wr_o[7:2]] = data_mem_wr_o;
		end
	end

	function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3,
			input int rd, input int rs1, input int rs2);
		return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], core_pkg::OP};
	endfunction

	function automatic logic [31:0] i_word(input logic [6:0] opc, input logic [2:0] f3,
			input int rd, input int rs1, input int imm);
		return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
	endfunction

	function automatic logic [31:0] s_word(input int rs1, input int rs2, input int imm);
		return {imm[11:5], rs2[4:0], rs1[4:0], core_pkg::F3_WORD, imm[4:0], core_pkg::STORE};
	endfunction

	function automatic logic [31:0] b_word(input logic [2:0] f3, input int rs1, input int rs2,
			input int imm);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], core_pkg::BRANCH};
	endfunction

	function automatic logic [31:0] j_word(input int rd, input int imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], core_pkg::JAL};
	endfunction

	function automatic logic [31:0] ram_word(input int idx);
		return (idx * 32'h9E37_79B9) ^ 32'h5A5A_0000;	// every index bit matters
	endfunction

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic check(input logic cond, input string msg);
		assert (cond) else begin
			errors++;
			$display("CHECK FAILED at %0t ns: %s", $time, msg);
		end
	endtask

	task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
	endtask

	task automatic apply_reset();
		@(negedge clk_i);
		rst_i   = 1'b1;
		stall_i = 1'b0;
		for (int i = 0; i < 64; i++) begin
			rom[i] = (i < prog.size()) ? prog[i] : core_pkg::INSTR_NOP;
			ram[i] = ram_word(i);
		end
		repeat (4) @(posedge clk_i);
		@(negedge clk_i);
		rst_i = 1'b0;
		log_addr.delete();
		log_data.delete();
		log_rd_addr.delete();
	endtask

	task automatic run_and_check(input string name, input bit with_stall);
		int cycles;
		cycles = 0;
		apply_reset();
		while (log_addr.size() < exp_addr.size() && cycles < RUN_LIMIT) begin
			@(negedge clk_i);
			if (with_stall) begin
				lcg_state = lcg_next(lcg_state);
				stall_i   = (lcg_state[18:16] < 3'd3);	// roughly one cycle in three
			end
			cycles++;
		end
		stall_i = 1'b0;
		if (log_addr.size() < exp_addr.size()) begin
			timeouts++;
			$display("timeout: program %s made %0d of %0d stores in %0d cycles",
				name, log_addr.size(), exp_addr.size(), cycles);
		end
		repeat (16) @(negedge clk_i);	// stray stores would land here
		check(log_addr.size() == exp_addr.size(), $sformatf("%s: %0d stores, expected %0d",
			name, log_addr.size(), exp_addr.size()));
		for (int i = 0; i < exp_addr.size() && i < log_addr.size(); i++) begin
			check(log_addr[i] == exp_addr[i], $sformatf("%s: store %0d at %h, expected %h",
				name, i, log_addr[i], exp_addr[i]));
			check(log_data[i] == exp_data[i], $sformatf("%s: store %0d data %h, expected %h",
				name, i, log_data[i], exp_data[i]));
		end
	endtask

	task automatic reset_values();
		prog = '{core_pkg::INSTR_NOP, core_pkg::INSTR_NOP, j_word(0, 0)};
		apply_reset();
		check(pc_o == RESET_PC, "pc_o differs from RESET_PC after reset");
		check(mem_rd_en_o == 1'b0, "mem_rd_en_o high after reset");
		check(mem_wr_en_o == 1'b0, "mem_wr_en_o high after reset");
		check(instr_rd_en_o == 1'b1, "instr_rd_en_o low after reset");
		@(negedge clk_i);
		check(pc_o == RESET_PC + 32'd4, "first fetch was not at RESET_PC");
	endtask

	task automatic alu_chain_program();
		logic [31:0] c1;
		logic [31:0] c2;
		logic [31:0] v3;
		logic [31:0] v4;
		logic [31:0] v5;
		logic [31:0] v6;
		logic [31:0] v7;
		c1 = 32'h5A3;
		c2 = 32'h2F0;
		v3 = c1 + c2;
		v4 = c1 - v3;
		v5 = v4 & v3;
		v6 = v5 | c2;
		v7 = v6 ^ c1;
		prog = '{i_word(core_pkg::OP_IMM, core_pkg::F3_ADD_SUB, 2, 0, 'h2F0),
			i_word(core_pkg::OP_IMM, core_pkg::F3_ADD_SUB, 1, 0, 'h5A3),
			r_word(core_pkg::F7_BASE, core_pkg::F3_ADD_SUB, 3, 1, 2),
			r_word(core_pkg::F7_SUB, core_pkg::F3_ADD_SUB, 4, 1, 3),
			r_word(core_pkg::F7_BASE, core_pkg::F3_AND, 5, 4, 3),
			r_word(core_pkg::F7_BASE, core_pkg::F3_OR, 6, 5, 2),
			r_word(core_pkg::F7_BASE, core_pkg::F3_XOR, 7, 6, 1),
			i_word(core_pkg::OP_IMM, core_pkg::F3_ADD_SUB, 8, 7, -5),
			s_word(0, 8, 20), s_word(0, 3, 0), s_word(0, 4, 4), s_word(0, 5, 8),
			s_word(0, 6, 12), s_word(0, 7, 16), j_word(0, 0)};
		exp_addr.delete();
		exp_data.delete();
		expect_store(32'd20, v7 - 32'd5);	// stored straight off the bypass
		expect_store(32'd0, v3);
		expect_store(32'd4, v4);
		expect_store(32'd8, v5);
		expect_store(32'd12, v6);
		expect_store(32'd16, v7);
	endtask

	task automatic load_use();
		prog = '{i_word(core_pkg::OP_IMM, core_pkg::F3_ADD_SUB, 1, 0, 40),
			i_word(core_pkg::LOAD, core_pkg::F3_WORD, 2, 1, 8),
			i_word(core_pkg::OP_IMM, core_pkg::F3_ADD_SUB, 3, 2, -100),
			s_word(1, 3, 4), j_word(0, 0)};
		exp_addr.delete();
		exp_data.delete();
		expect_store(32'd44, ram_word(12) - 32'd100);	// lw from byte 48
		run_and_check("load use", 1'b0);
		check(log_rd_addr.size() == 1 && log_rd_addr[0] == 32'd48,
			$sformatf("load use: %0d data reads, expected one at byte 48", log_rd_addr.size()));
	endtask

	task automatic branches();
		prog = '{i_word(core_pkg::OP_IMM, core_pkg::F3_ADD_SUB, 1, 0, 7),
			i_word(core_pkg::OP_IMM, core_pkg::F3_ADD_SUB, 2, 0, 7),
			b_word(core_pkg::F3_BEQ, 1, 2, 8), s_word(0, 1, 0), s_word(0, 1, 4),
			b_word(core_pkg::F3_BNE, 1, 2, 8), s_word(0, 2, 8),
			i_word(core_pkg::OP_IMM, core_pkg::F3_ADD_SUB, 3, 0, 9),
			b_word(core_pkg::F3_BEQ, 1, 3, 8), s_word(0, 3, 12),
			b_word(core_pkg::F3_BNE, 1, 3, 8), s_word(0, 3, 16),
			j_word(5, 8), s_word(0, 1, 20), s_word(0, 5, 24), j_word(0, 0)};
		exp_addr.delete();
		exp_data.delete();
		expect_store(32'd4, 32'd7);
		expect_store(32'd8, 32'd7);
		expect_store(32'd12, 32'd9);
		expect_store(32'd24, RESET_PC + 32'd48 + 32'd4);	// link of jal at word 12
		run_and_check("branches and jal", 1'b0);
	endtask

	task automatic x0_store();
		prog = '{i_word(core_pkg::OP_IMM, core_pkg::F3_ADD_SUB, 0, 0, 123),
			s_word(0, 0, 28), j_word(0, 0)};
		exp_addr.delete();
		exp_data.delete();
		expect_store(32'd28, 32'd0);
		run_and_check("x0 store", 1'b0);
	endtask

	initial begin
		rst_i     = 1'b1;
		stall_i   = 1'b0;
		errors    = 0;
		timeouts  = 0;
		lcg_state = 32'd48;
		reset_values();
		alu_chain_program();
		run_and_check("alu chain", 1'b0);
		saved_data = log_data;
		load_use();
		branches();
		alu_chain_program();
		run_and_check("alu chain with stalls", 1'b1);
		check(log_data == saved_data, "stalled alu chain log differs from the unstalled one");
		x0_store();
		$display("tests done: %0d check errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// ==== list.f ====
common/core_pkg.sv
src/pc.sv
src/if_stage.sv
id_stage/id_stage.sv
src/regs.sv
ex_stage/ex_stage.sv
src/ctrl.sv
src/core.sv
tb/tb_core.sv

// ==== run.sh ====
#!/usr/bin/env bash
# compile the core testbench with verilator and run it

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module tb_core -Mdir build -o tb_core -f list.f \
	&& ./build/tb_core > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "compile or run failed"; exit 1; }

cat sim.log
grep -q "ERRORS FOUND" sim.log && { echo "simulation failed"; exit 1; }
grep -q "NO ERRORS" sim.log || { echo "no result in log"; exit 1; }
echo "simulation passed"
